// ==== cb_pkg.sv ====
/*
 * Control board shared definitions
 * Bus widths, register map, bit positions and FSM states
 */
package cb_pkg;

    localparam int ADDR_W  = 8;                 // Register address width
    localparam int DATA_W  = 16;                // Register data width
    localparam int RELAY_W = 4;
    localparam int TTL_W   = 6;
    localparam int LVTTL_W = 8;

    localparam logic [DATA_W-1:0] BOARD_ID = 16'hCB17;
    localparam logic RELAY_OEN_RST = 1'b1;      // Relay buffers off after reset

    // ****************************************************************
    // Register bit map
    // ****************************************************************
    localparam int RELAY_OEN_BIT = 4;           // REG_RELAY output enable, active low
    localparam int TTL_EN_BIT    = 8;           // REG_TTL driver enable
    localparam int STATUS_LV_LSB = 8;           // REG_STATUS lvttl field
    localparam int STATUS_LV_W   = 5;           // Low LVTTL pins seen as plain inputs

    // Encoder pins on the LVTTL connector
    localparam int ENC_A_IDX = 5;
    localparam int ENC_B_IDX = 6;
    localparam int ENC_Z_IDX = 7;

    typedef enum logic [ADDR_W-1:0] {
        REG_ID       = 8'h00,
        REG_RELAY    = 8'h01,
        REG_TTL      = 8'h02,
        REG_STATUS   = 8'h03,
        REG_ENC_CTRL = 8'h04,                   // Bit 0 clears the counters
        REG_ENC_POS  = 8'h05,
        REG_ENC_REV  = 8'h06,
        REG_IRQ      = 8'h07                    // Index flag, write 1 to clear
    } reg_addr_e;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_ACCESS,
        BR_CAPTURE,
        BR_HOLD
    } bridge_state_e;

endpackage

// ==== cb_ifs.sv ====
/*
 * Internal buses of the control board
 * Register bus from the bridge and encoder link to the counter
 */
`timescale 1ns/1ps

interface lbs_if;
    import cb_pkg::*;

    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;                   // Combinational, valid with re
    logic              we;                      // One-cycle pulse
    logic              re;                      // One-cycle pulse

    modport master (output addr, wdata, we, re, input rdata);
    modport slave  (input addr, wdata, we, re, output rdata);
endinterface

interface enc_if;
    import cb_pkg::*;

    logic              clear;                   // Zero both counters
    logic [DATA_W-1:0] pos;
    logic [DATA_W-1:0] rev;
    logic              index_evt;               // Z edge seen

    modport ctrl (output clear, input pos, rev, index_evt);
    modport cnt  (input clear, output pos, rev, index_evt);
endinterface

// ==== lbs_bridge.sv ====
/*
 * DSP local bus bridge
 * Resamples the asynchronous bus and issues one register cycle per chip select
 */
`timescale 1ns/1ps

module lbs_bridge (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      bus_cs_n_i,
    input  logic                      bus_rw_n_i,
    input  logic [cb_pkg::ADDR_W-1:0] bus_addr_i,
    input  logic [cb_pkg::DATA_W-1:0] bus_wdata_i,
    output logic [cb_pkg::DATA_W-1:0] bus_rdata_o,
    output logic                      bus_wait_o,
    lbs_if.master                     lbs
);
    import cb_pkg::*;

    bridge_state_e     state_q;
    logic [1:0]        cs_n_sync;
    logic [1:0]        rw_n_sync;
    logic [ADDR_W-1:0] addr_s1;
    logic [ADDR_W-1:0] addr_s2;
    logic [DATA_W-1:0] wdata_s1;
    logic [DATA_W-1:0] wdata_s2;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              rd_q;
    logic              we_q;
    logic              re_q;
    logic              start;

    // ****************************************************************
    // Two-flop resampling of the DSP side
    // ****************************************************************
    always_ff @(posedge clk)
    begin
        if (rst_i)
            cs_n_sync <= 2'b11;                 // Bus idle
        else
            cs_n_sync <= {cs_n_sync[0], bus_cs_n_i};
    end

    always_ff @(posedge clk)
    begin
        rw_n_sync <= {rw_n_sync[0], bus_rw_n_i};
        addr_s1   <= bus_addr_i;
        addr_s2   <= addr_s1;
        wdata_s1  <= bus_wdata_i;
        wdata_s2  <= wdata_s1;
    end

    assign start = (state_q == BR_IDLE) && !cs_n_sync[1];

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q    <= BR_IDLE;
            bus_wait_o <= 1'b0;
            we_q       <= 1'b0;
            re_q       <= 1'b0;
        end
        else
        begin
            we_q <= 1'b0;
            re_q <= 1'b0;
            case (state_q)
                BR_IDLE:
                begin
                    if (start)
                    begin
                        state_q    <= BR_ACCESS;
                        bus_wait_o <= 1'b1;     // Hold the DSP off
                    end
                end
                BR_ACCESS:
                begin
                    we_q    <= !rd_q;
                    re_q    <= rd_q;
                    state_q <= BR_CAPTURE;
                end
                BR_CAPTURE:
                begin
                    bus_wait_o <= 1'b0;
                    state_q    <= BR_HOLD;
                end
                BR_HOLD:
                begin
                    if (cs_n_sync[1])           // Window closed by the DSP
                        state_q <= BR_IDLE;
                end
                default: state_q <= BR_IDLE;
            endcase
        end
    end

    // Access is frozen for the whole window
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            addr_q  <= addr_s2;
            wdata_q <= wdata_s2;
            rd_q    <= rw_n_sync[1];
        end
        if (state_q == BR_CAPTURE && re_q)
            bus_rdata_o <= lbs.rdata;           // Kept until the next read
    end

    assign lbs.addr  = addr_q;
    assign lbs.wdata = wdata_q;
    assign lbs.we    = we_q;
    assign lbs.re    = re_q;

    a_one_strobe: assert property (@(posedge clk) disable iff (rst_i)
        !(lbs.we && lbs.re));

endmodule

// ==== sys_regs.sv ====
/*
 * System register block
 * Board ID, relay and TTL control, input status, encoder access and index IRQ
 */
`timescale 1ns/1ps

module sys_regs (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [cb_pkg::TTL_W-1:0]       ttl_i,
    input  logic [cb_pkg::STATUS_LV_W-1:0] lvttl_lo_i,
    output logic [cb_pkg::RELAY_W-1:0]     relay_con_o,
    output logic                           relay_oen_o,
    output logic [cb_pkg::TTL_W-1:0]       ttl_o,
    output logic                           ttl_en_o,
    output logic                           irq_o,
    lbs_if.slave                           lbs,
    enc_if.ctrl                            enc
);
    import cb_pkg::*;

    reg_addr_e              addr;
    logic [TTL_W-1:0]       ttl_s1;
    logic [TTL_W-1:0]       ttl_s2;
    logic [STATUS_LV_W-1:0] lv_s1;
    logic [STATUS_LV_W-1:0] lv_s2;
    logic [DATA_W-1:0]      rdata;
    logic                   clear_q;
    logic                   irq_flag;

    assign addr = reg_addr_e'(lbs.addr);

    // Input pins are asynchronous to clk
    always_ff @(posedge clk)
    begin
        ttl_s1 <= ttl_i;
        ttl_s2 <= ttl_s1;
        lv_s1  <= lvttl_lo_i;
        lv_s2  <= lv_s1;
    end

    // ****************************************************************
    // Control registers
    // ****************************************************************
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            relay_con_o <= '0;
            relay_oen_o <= RELAY_OEN_RST;
            ttl_o       <= '0;
            ttl_en_o    <= 1'b0;
            clear_q     <= 1'b0;
        end
        else
        begin
            clear_q <= 1'b0;
            if (lbs.we)
            begin
                case (addr)
                    REG_RELAY:
                    begin
                        relay_con_o <= lbs.wdata[RELAY_W-1:0];
                        relay_oen_o <= lbs.wdata[RELAY_OEN_BIT];
                    end
                    REG_TTL:
                    begin
                        ttl_o    <= lbs.wdata[TTL_W-1:0];
                        ttl_en_o <= lbs.wdata[TTL_EN_BIT];
                    end
                    REG_ENC_CTRL: clear_q <= lbs.wdata[0];  // Self-clearing
                    default: ;
                endcase
            end
        end
    end

    // Index flag, a new event beats a clear
    always_ff @(posedge clk)
    begin
        if (rst_i)
            irq_flag <= 1'b0;
        else if (enc.index_evt)
            irq_flag <= 1'b1;
        else if (lbs.we && addr == REG_IRQ && lbs.wdata[0])
            irq_flag <= 1'b0;
    end

    assign irq_o     = irq_flag;
    assign enc.clear = clear_q;

    // Read mux
    always_comb
    begin
        rdata = '0;
        case (addr)
            REG_ID:      rdata = BOARD_ID;
            REG_RELAY:
            begin
                rdata[RELAY_W-1:0]   = relay_con_o;
                rdata[RELAY_OEN_BIT] = relay_oen_o;
            end
            REG_TTL:
            begin
                rdata[TTL_W-1:0]  = ttl_o;
                rdata[TTL_EN_BIT] = ttl_en_o;
            end
            REG_STATUS:
            begin
                rdata[TTL_W-1:0]                           = ttl_s2;
                rdata[STATUS_LV_LSB +: STATUS_LV_W]        = lv_s2;
            end
            REG_ENC_POS: rdata = enc.pos;
            REG_ENC_REV: rdata = enc.rev;
            REG_IRQ:     rdata[0] = irq_flag;
            default:     rdata = '0;        // Unmapped and write-only
        endcase
    end

    assign lbs.rdata = rdata;

    a_irq_from_index: assert property (@(posedge clk) disable iff (rst_i)
        $rose(irq_o) |-> $past(enc.index_evt));

endmodule

// ==== quad_counter.sv ====
/*
 * Quadrature encoder counter
 * Counts A/B Gray steps and counts revolutions on the Z index
 */
`timescale 1ns/1ps

module quad_counter (
    input  logic clk,
    input  logic rst_i,
    input  logic a_i,
    input  logic b_i,
    input  logic z_i,
    enc_if.cnt   enc
);
    import cb_pkg::*;

    logic [1:0]        a_sync;
    logic [1:0]        b_sync;
    logic [1:0]        z_sync;
    logic [1:0]        ab_prev;
    logic              z_prev;
    logic [1:0]        ab_cur;
    logic              step;
    logic              up;
    logic              z_rise;
    logic              dir_q;
    logic [DATA_W-1:0] pos_q;
    logic [DATA_W-1:0] rev_q;
    logic              evt_q;

    // ****************************************************************
    // Pin resampling and edge history
    // ****************************************************************
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            a_sync  <= '0;
            b_sync  <= '0;
            z_sync  <= '0;
            ab_prev <= '0;
            z_prev  <= 1'b0;
        end
        else
        begin
            a_sync  <= {a_sync[0], a_i};
            b_sync  <= {b_sync[0], b_i};
            z_sync  <= {z_sync[0], z_i};
            ab_prev <= ab_cur;
            z_prev  <= z_sync[1];
        end
    end

    assign ab_cur = {a_sync[1], b_sync[1]};
    assign step   = ^(ab_cur ^ ab_prev);    // Exactly one line moved
    assign up     = ab_cur[1] ^ ab_prev[0]; // A leads B
    assign z_rise = z_sync[1] && !z_prev;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            pos_q <= '0;
            rev_q <= '0;
            dir_q <= 1'b1;
            evt_q <= 1'b0;
        end
        else
        begin
            evt_q <= z_rise;
            if (step)
                dir_q <= up;
            if (enc.clear)
            begin
                pos_q <= '0;
                rev_q <= '0;
            end
            else if (z_rise)
            begin
                pos_q <= '0;                    // Index realigns the position
                rev_q <= dir_q ? rev_q + DATA_W'(1) : rev_q - DATA_W'(1);
            end
            else if (step)
                pos_q <= up ? pos_q + DATA_W'(1) : pos_q - DATA_W'(1);
        end
    end

    assign enc.pos       = pos_q;
    assign enc.rev       = rev_q;
    assign enc.index_evt = evt_q;

    a_pos_step: assert property (@(posedge clk) disable iff (rst_i)
        (enc.pos != $past(enc.pos)) |-> (enc.pos == '0
            || enc.pos == $past(enc.pos) + DATA_W'(1)
            || enc.pos == $past(enc.pos) - DATA_W'(1)));

endmodule

// ==== control_board.sv ====
/*
 * Control board top level
 * DSP bus bridge, system registers and encoder counter on board pins
 */
`timescale 1ns/1ps

module control_board (
    input  logic                       clk,
    input  logic                       rst_i,
    // DSP local bus
    input  logic                       bus_cs_n_i,
    input  logic                       bus_rw_n_i,     // 1 reads
    input  logic [cb_pkg::ADDR_W-1:0]  bus_addr_i,
    input  logic [cb_pkg::DATA_W-1:0]  bus_wdata_i,
    output logic [cb_pkg::DATA_W-1:0]  bus_rdata_o,
    output logic                       bus_wait_o,
    // Board pins
    output logic [cb_pkg::RELAY_W-1:0] relay_con_o,
    output logic                       relay_oen_o,    // Active low
    input  logic [cb_pkg::TTL_W-1:0]   ttl_i,
    output logic [cb_pkg::TTL_W-1:0]   ttl_o,
    output logic                       ttl_en_o,
    input  logic [cb_pkg::LVTTL_W-1:0] lvttl_i,
    output logic                       irq_o
);
    import cb_pkg::*;

    lbs_if lbs_bus ();
    enc_if enc_bus ();

    lbs_bridge u_lbs_bridge (
        .clk         (clk),
        .rst_i       (rst_i),
        .bus_cs_n_i  (bus_cs_n_i),
        .bus_rw_n_i  (bus_rw_n_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_wait_o  (bus_wait_o),
        .lbs         (lbs_bus.master)
    );

    sys_regs u_sys_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .ttl_i       (ttl_i),
        .lvttl_lo_i  (lvttl_i[STATUS_LV_W-1:0]),    // Plain status inputs
        .relay_con_o (relay_con_o),
        .relay_oen_o (relay_oen_o),
        .ttl_o       (ttl_o),
        .ttl_en_o    (ttl_en_o),
        .irq_o       (irq_o),
        .lbs         (lbs_bus.slave),
        .enc         (enc_bus.ctrl)
    );

    // Encoder sits on the upper LVTTL pins
    quad_counter u_quad_counter (
        .clk   (clk),
        .rst_i (rst_i),
        .a_i   (lvttl_i[ENC_A_IDX]),
        .b_i   (lvttl_i[ENC_B_IDX]),
        .z_i   (lvttl_i[ENC_Z_IDX]),
        .enc   (enc_bus.cnt)
    );

endmodule

// ==== tb_control_board.sv ====
/*
 * Control board testbench
 * Replays the vector file over the DSP bus, encoder pins and board outputs
 */
`timescale 1ns/1ps

module tb_control_board;

    localparam int HOLD_CYCLES = 6;             // Encoder state and Z pulse length
    localparam int WAIT_LIMIT  = 40;            // Clocks allowed per wait-line edge
    localparam int ENC_A       = 5;
    localparam int ENC_B       = 6;
    localparam int ENC_Z       = 7;

    logic        clk;
    logic        rst_i;
    logic        bus_cs_n_i;
    logic        bus_rw_n_i;
    logic [7:0]  bus_addr_i;
    logic [15:0] bus_wdata_i;
    logic [15:0] bus_rdata_o;
    logic        bus_wait_o;
    logic [3:0]  relay_con_o;
    logic        relay_oen_o;
    logic [5:0]  ttl_i;
    logic [5:0]  ttl_o;
    logic        ttl_en_o;
    logic [7:0]  lvttl_i;
    logic        irq_o;

    logic [31:0]      lfsr_q;
    logic [1:0]       enc_phase;
    int               err_count;
    int               check_count;
    int               test_count;
    int               test_errs;
    logic             in_test;
    logic             aborted;
    logic [8*32-1:0]  test_name;
    logic [8*128-1:0] line_buf;
    int               fd;
    int               code;
    int               c;
    logic             at_eof;
    logic [7:0]       kind;
    logic [31:0]      arg1;
    logic [31:0]      arg2;
    logic [31:0]      arg3;
    logic [31:0]      arg4;
    logic [31:0]      arg5;
    logic [15:0]      rdata;

    control_board i_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .bus_cs_n_i  (bus_cs_n_i),
        .bus_rw_n_i  (bus_rw_n_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_wait_o  (bus_wait_o),
        .relay_con_o (relay_con_o),
        .relay_oen_o (relay_oen_o),
        .ttl_i       (ttl_i),
        .ttl_o       (ttl_o),
        .ttl_en_o    (ttl_en_o),
        .lvttl_i     (lvttl_i),
        .irq_o       (irq_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    // ******************************************************************
    // Helpers
    // ******************************************************************
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // A leads B going forward, A in bit 1
    function automatic logic [1:0] gray_ab(input logic [1:0] phase);
        case (phase)
            2'd0:    return 2'b00;
            2'd1:    return 2'b10;
            2'd2:    return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[14:0], lfsr_q[0]};           // One step per bit
        end
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            $display("[ERROR] %0t %0s: got %h, expected %h", $time, what, actual, expected);
            err_count++;
        end
    endtask

    // Field count of the line just scanned
    task automatic require_fields(input int n);
        if (code != n)
        begin
            $display("Line of kind %c in the vector file is malformed", kind);
            aborted = 1'b1;
        end
    endtask

    // One DSP access, chip select held until the bridge drops wait
    task automatic bus_access(input logic rw_n, input logic [7:0] addr,
                              input logic [15:0] wdata, output logic [15:0] rd);
        int cnt;
        rd = '0;
        @(posedge clk);
        bus_cs_n_i  <= 1'b0;
        bus_rw_n_i  <= rw_n;
        bus_addr_i  <= addr;
        bus_wdata_i <= wdata;
        cnt = 0;
        while (!bus_wait_o && cnt < WAIT_LIMIT)
        begin
            @(posedge clk);
            cnt++;
        end
        if (!bus_wait_o)
        begin
            $display("Bus wait line never rose for address %h", addr);
            aborted = 1'b1;
        end
        else
        begin
            cnt = 0;
            while (bus_wait_o && cnt < WAIT_LIMIT)
            begin
                @(posedge clk);
                cnt++;
            end
            if (bus_wait_o)
            begin
                $display("Bus wait line stuck high for address %h", addr);
                aborted = 1'b1;
            end
            else
                rd = bus_rdata_o;
        end
        @(posedge clk);
        bus_cs_n_i <= 1'b1;
        repeat (5) @(posedge clk);              // Let the bridge see the window close
    endtask

    task automatic enc_steps(input int n, input logic forward);
        int i;
        logic [1:0] ab;
        for (i = 0; i < n; i++)
        begin
            enc_phase = forward ? enc_phase + 2'd1 : enc_phase - 2'd1;
            ab = gray_ab(enc_phase);
            @(posedge clk);
            lvttl_i[ENC_A] <= ab[1];
            lvttl_i[ENC_B] <= ab[0];
            repeat (HOLD_CYCLES - 1) @(posedge clk);
        end
    endtask

    task automatic index_pulse();
        @(posedge clk);
        lvttl_i[ENC_Z] <= 1'b1;
        repeat (HOLD_CYCLES - 1) @(posedge clk);
        @(posedge clk);
        lvttl_i[ENC_Z] <= 1'b0;
        repeat (HOLD_CYCLES - 1) @(posedge clk);
    endtask

    // Random pins, then REG_STATUS must show them at bits 5:0 and 12:8
    task automatic status_rounds(input int n);
        int i;
        logic [15:0] rnd_ttl;
        logic [15:0] rnd_lv;
        logic [15:0] expected;
        for (i = 0; i < n && !aborted; i++)
        begin
            draw_bits(6, rnd_ttl);
            draw_bits(5, rnd_lv);
            @(posedge clk);
            ttl_i        <= rnd_ttl[5:0];
            lvttl_i[4:0] <= rnd_lv[4:0];
            expected        = '0;
            expected[5:0]   = rnd_ttl[5:0];
            expected[12:8]  = rnd_lv[4:0];
            bus_access(1'b1, 8'h03, 16'h0000, rdata);  // Sync settles during the access
            if (!aborted)
                check_value(32'(rdata), 32'(expected), "status word");
        end
    endtask

    task automatic check_pins();
        check_value(32'(relay_con_o), arg1, "relay_con_o");
        check_value(32'(relay_oen_o), arg2, "relay_oen_o");
        check_value(32'(ttl_o), arg3, "ttl_o");
        check_value(32'(ttl_en_o), arg4, "ttl_en_o");
        check_value(32'(irq_o), arg5, "irq_o");
    endtask

    task automatic close_test();
        if (in_test)
        begin
            test_count++;
            if (aborted)
                $display("test %0s: aborted", test_name);
            else if (err_count == test_errs)
                $display("test %0s: ok", test_name);
            else
                $display("test %0s: %0d errors", test_name, err_count - test_errs);
        end
        in_test = 1'b0;
    endtask

    // Next line kind, whitespace skipped
    task automatic read_kind();
        c = $fgetc(fd);
        while (c == 32 || c == 10 || c == 13 || c == 9)
            c = $fgetc(fd);
        at_eof = (c == -1);
        kind   = c[7:0];
    endtask

    // ******************************************************************
    // Test runner
    // ******************************************************************
    initial
    begin
        rst_i       <= 1'b1;
        bus_cs_n_i  <= 1'b1;
        bus_rw_n_i  <= 1'b1;
        bus_addr_i  <= '0;
        bus_wdata_i <= '0;
        ttl_i       <= '0;
        lvttl_i     <= '0;
        lfsr_q      = 32'hb7be_8d33;
        enc_phase   = 2'd0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_errs   = 0;
        in_test     = 1'b0;
        aborted     = 1'b0;
        at_eof      = 1'b0;
        test_name   = '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);

        fd = $fopen("control_board_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open control_board_tests.txt");
            aborted = 1'b1;
        end
        else
        begin
            read_kind();
            while (!at_eof && !aborted)
            begin
                case (kind)
                    "#": code = $fgets(line_buf, fd);
                    "T":
                    begin
                        close_test();
                        code      = $fscanf(fd, " %s", test_name);
                        require_fields(1);
                        in_test   = 1'b1;
                        test_errs = err_count;
                    end
                    "W":
                    begin
                        code = $fscanf(fd, " %h %h", arg1, arg2);
                        require_fields(2);
                        if (!aborted)
                            bus_access(1'b0, arg1[7:0], arg2[15:0], rdata);
                    end
                    "R":
                    begin
                        code = $fscanf(fd, " %h %h", arg1, arg2);
                        require_fields(2);
                        if (!aborted)
                            bus_access(1'b1, arg1[7:0], 16'h0000, rdata);
                        if (!aborted)
                            check_value(32'(rdata), arg2,
                                        $sformatf("read of address %h", arg1[7:0]));
                    end
                    "F":
                    begin
                        code = $fscanf(fd, " %h", arg1);
                        require_fields(1);
                        if (!aborted)
                            enc_steps(int'(arg1), 1'b1);
                    end
                    "B":
                    begin
                        code = $fscanf(fd, " %h", arg1);
                        require_fields(1);
                        if (!aborted)
                            enc_steps(int'(arg1), 1'b0);
                    end
                    "Z": index_pulse();
                    "S":
                    begin
                        code = $fscanf(fd, " %h", arg1);
                        require_fields(1);
                        if (!aborted)
                            status_rounds(int'(arg1));
                    end
                    "P":
                    begin
                        code = $fscanf(fd, " %h %h %h %h %h", arg1, arg2, arg3, arg4, arg5);
                        require_fields(5);
                        if (!aborted)
                            check_pins();
                    end
                    default:
                    begin
                        $display("Unknown line kind %c in the vector file", kind);
                        aborted = 1'b1;
                    end
                endcase
                if (!aborted)
                    read_kind();
            end
            $fclose(fd);
        end

        close_test();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0 && !aborted)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== control_board_tests.txt ====
# Kinds: T name | W addr data | R addr expect | F n | B n | Z | S rounds
# P relay_con relay_oen ttl ttl_en irq, all numbers hex
T reset_id
P 0 1 00 0 0
R 00 cb17
R 05 0000
R 06 0000
R 07 0000
T control_writes
W 01 0005
R 01 0005
P 5 0 00 0 0
W 01 ffff
R 01 001f
P f 1 00 0 0
W 02 012a
R 02 012a
P f 1 2a 1 0
W 02 fe15
R 02 0015
P f 1 15 0 0
R 04 0000
R 08 0000
R 3c 0000
T input_status
S 8
T encoder_count
F 0a
R 05 000a
B 0d
R 05 fffd
F 03
R 05 0000
T index
F 05
R 05 0005
Z
P f 1 15 0 1
R 07 0001
R 05 0000
R 06 0001
W 07 0001
P f 1 15 0 0
R 07 0000
B 02
R 05 fffe
Z
R 05 0000
R 06 0000
W 07 0001
T counter_clear
F 07
R 05 0007
Z
R 06 0001
W 04 0001
R 05 0000
R 06 0000
F 04
R 05 0004
B 01
R 05 0003
W 07 0001
P f 1 15 0 0

// ==== tb.f ====
cb_pkg.sv
cb_ifs.sv
lbs_bridge.sv
sys_regs.sv
quad_counter.sv
control_board.sv
tb_control_board.sv

// ==== Makefile ====
# Verilator build and run for the control board testbench

TOP     ?= tb_control_board
SIM_DIR ?= obj_dir
LOG     ?= sim.log
VFLAGS  ?= --assert

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f tb.f

run: build
	./$(SIM_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF -- '** PASS **' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing $(VFLAGS) --top-module $(TOP) -f tb.f

clean:
	rm -rf $(SIM_DIR) $(LOG)
